//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal -j 0
TOP     = issue_slice_tb
FLIST   = issue_slice.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
PASS    = All tests passed!
SOURCES = $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the pattern file path is relative to the project root
run: $(BIN) sim/issue_slice_patterns.txt
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- issue_slice.f
+incdir+source
source/uop_pkg.sv
source/csr_pkg.sv
source/issue_ctrl_regs.sv
source/busy_scoreboard.sv
source/alu_issue_queue.sv
source/prf_alu_exec.sv
source/issue_slice_top.sv
sim/tb_clock_gen.sv
sim/issue_slice_props.sv
sim/issue_slice_tb.sv

//--- sim/issue_slice_patterns.txt
// columns: kind addr op prd prs1 prs2 data expect, all hex
// kind 1 dispatch, 2 dispatch dropped by a flush, 3 dispatch held by a full queue,
// 4 apb write, 5 apb read, 6 wait for drain, 0 end
// CTRL after reset
5 0 0 00 00 00 00000000 00000001
// operands, then one op of each kind
1 0 7 01 00 00 00000013 00000013
1 0 7 02 00 00 fffffff9 fffffff9
1 0 7 03 00 00 00000004 00000004
6 0 0 00 00 00 00000000 00000000
1 0 0 04 01 02 00000000 0000000c
1 0 1 05 01 02 00000000 0000001a
1 0 2 06 01 02 00000000 00000011
1 0 3 07 01 02 00000000 fffffffb
1 0 4 08 01 02 00000000 ffffffea
1 0 5 09 02 01 00000000 00000001
1 0 6 0a 01 03 00000000 00000130
// dependent chain, back to back
1 0 0 0b 0a 01 00000000 00000143
1 0 1 0c 0b 03 00000000 0000013f
1 0 4 0d 0c 0b 00000000 0000007c
1 0 6 0e 0d 03 00000000 000007c0
1 0 7 0f 00 00 00000005 00000005
1 0 0 10 0e 0f 00000000 000007c5
6 0 0 00 00 00 00000000 00000000
// issue disabled, queue fills, ninth op waits
4 0 0 00 00 00 00000000 00000000
5 0 0 00 00 00 00000000 00000000
1 0 7 11 00 00 00000100 00000100
1 0 7 12 00 00 00000023 00000023
1 0 0 13 11 12 00000000 00000123
1 0 3 14 13 01 00000000 00000133
1 0 1 15 14 12 00000000 00000110
1 0 2 16 15 14 00000000 00000110
1 0 5 17 02 16 00000000 00000001
1 0 4 18 17 11 00000000 00000101
3 0 0 19 18 13 00000000 00000224
5 4 0 00 00 00 00000000 00000008
4 0 0 00 00 00 00000001 00000000
6 0 0 00 00 00 00000000 00000000
5 4 0 00 00 00 00000000 00000000
// queued ops flushed, old contents of p10 survive
4 0 0 00 00 00 00000000 00000000
2 0 7 0a 00 00 0000dead 00000000
2 0 0 1a 0a 01 00000000 00000000
4 0 0 00 00 00 00000002 00000000
5 4 0 00 00 00 00000000 00000000
5 0 0 00 00 00 00000000 00000000
4 0 0 00 00 00 00000001 00000000
1 0 0 1b 0a 01 00000000 00000143
1 0 1 1c 0a 03 00000000 0000012c
6 0 0 00 00 00 00000000 00000000
0 0 0 00 00 00 00000000 00000000

//--- sim/issue_slice_props.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module issue_slice_props (
    input logic                    aclk,
    input logic                    rst_n_i,
    input logic                    flush_i,
    input logic                    issue_en_i,
    input logic                    issue_valid_i,
    input logic                    dispatch_ready_i,
    input logic                    wb_valid_i,
    input logic [`ISSUE_IQ_CW-1:0] iq_count_i
);

    localparam logic [`ISSUE_IQ_CW-1:0] FULL_COUNT = `ISSUE_IQ_CW'(`ISSUE_IQ_DEPTH);

    // flush clears the execute register on the same edge
    flush_kills_wb: assert property (@(posedge aclk) disable iff (!rst_n_i)
        flush_i |=> !wb_valid_i)
        else $error("writeback valid in the cycle after a flush");

    count_in_range: assert property (@(posedge aclk) disable iff (!rst_n_i)
        iq_count_i <= FULL_COUNT)
        else $error("issue queue occupancy above its depth");

    // the issue register follows the select by one edge
    no_issue_when_disabled: assert property (@(posedge aclk) disable iff (!rst_n_i)
        !issue_en_i |=> !issue_valid_i)
        else $error("op issued while issue was disabled");

    full_blocks_dispatch: assert property (@(posedge aclk) disable iff (!rst_n_i)
        (iq_count_i == FULL_COUNT) |-> !dispatch_ready_i)
        else $error("dispatch ready with a full queue");

endmodule

bind issue_slice_top issue_slice_props u_props (
    .aclk             (aclk),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush),
    .issue_en_i       (issue_en),
    .issue_valid_i    (issue_valid),
    .dispatch_ready_i (dispatch_ready_o),
    .wb_valid_i       (wb_valid_o),
    .iq_count_i       (iq_count)
);

//--- sim/issue_slice_tb.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module issue_slice_tb;
    import uop_pkg::*;

    localparam int    MAX_REC   = 64;
    localparam int    REC_W     = 8;
    localparam int    WD_CYCLES = 200;
    localparam string PAT_FILE  = "sim/issue_slice_patterns.txt";

    // record kinds in the pattern file
    localparam logic [31:0] REC_END   = 32'h0;
    localparam logic [31:0] REC_OP    = 32'h1;
    localparam logic [31:0] REC_DROP  = 32'h2;
    localparam logic [31:0] REC_HELD  = 32'h3;
    localparam logic [31:0] REC_WRITE = 32'h4;
    localparam logic [31:0] REC_READ  = 32'h5;
    localparam logic [31:0] REC_DRAIN = 32'h6;

    logic                        aclk;
    logic                        rst_n;
    logic [`ISSUE_APB_AW-1:0]    paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [31:0]                 pwdata;
    logic [31:0]                 prdata;
    logic                        dispatch_valid;
    logic                        dispatch_ready;
    alu_op_e                     dispatch_op;
    prf_num_t                    dispatch_prd;
    prf_num_t                    dispatch_prs1;
    prf_num_t                    dispatch_prs2;
    xlen_t                       dispatch_imm;
    logic                        wb_valid;
    prf_num_t                    wb_prd;
    xlen_t                       wb_data;

    logic [31:0]                 pat_mem [MAX_REC*REC_W];
    int                          rec_count;
    logic                        loaded;
    logic                        held;
    logic [16:0]                 lfsr_q;
    logic [`ISSUE_PRF_DEPTH-1:0] pending;
    xlen_t                       exp_val [`ISSUE_PRF_DEPTH];

    tb_clock_gen u_clock_gen (
        .aclk    (aclk),
        .rst_n_o (rst_n)
    );

    issue_slice_top UUT (
        .aclk             (aclk),
        .rst_n_i          (rst_n),
        .paddr_i          (paddr),
        .psel_i           (psel),
        .penable_i        (penable),
        .pwrite_i         (pwrite),
        .pwdata_i         (pwdata),
        .prdata_o         (prdata),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_ready_o (dispatch_ready),
        .dispatch_op_i    (dispatch_op),
        .dispatch_prd_i   (dispatch_prd),
        .dispatch_prs1_i  (dispatch_prs1),
        .dispatch_prs2_i  (dispatch_prs2),
        .dispatch_imm_i   (dispatch_imm),
        .wb_valid_o       (wb_valid),
        .wb_prd_o         (wb_prd),
        .wb_data_o        (wb_data)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    // two lfsr bits give 0 to 3 idle cycles
    task automatic idle_gap();
        int gap;
        lfsr_q = lfsr_step(lfsr_q);
        gap    = int'(lfsr_q[0]);
        lfsr_q = lfsr_step(lfsr_q);
        gap    = gap * 2 + int'(lfsr_q[0]);
        repeat (gap) @(negedge aclk);
    endtask

    task automatic load_op(input int b);
        dispatch_op    = alu_op_e'(pat_mem[b+2][2:0]);
        dispatch_prd   = prf_num_t'(pat_mem[b+3]);
        dispatch_prs1  = prf_num_t'(pat_mem[b+4]);
        dispatch_prs2  = prf_num_t'(pat_mem[b+5]);
        dispatch_imm   = pat_mem[b+6];
        dispatch_valid = 1'b1;
    endtask

    task automatic expect_writeback(input int b);
        prf_num_t prd;
        prd          = prf_num_t'(pat_mem[b+3]);
        pending[prd] = 1'b1;
        exp_val[prd] = pat_mem[b+7];
    endtask

    // valid stays up until a rising edge sees ready
    task automatic complete_dispatch();
        while (!dispatch_ready) @(negedge aclk);
        @(negedge aclk);
        dispatch_valid = 1'b0;
        held           = 1'b0;
    endtask

    task automatic finish_held();
        if (held) begin
            complete_dispatch();
        end
    endtask

    task automatic send_op(input int b, input logic check_wb);
        finish_held();
        idle_gap();
        if (check_wb) begin
            expect_writeback(b);
        end
        load_op(b);
        complete_dispatch();
    endtask

    // with the queue full ready is low and the op stays on the port
    task automatic present_held_op(input int b);
        finish_held();
        expect_writeback(b);
        load_op(b);
        held = 1'b1;
        assert (!dispatch_ready)
            else abort_run($sformatf("CHECK FAILED at %0t: dispatch ready with a full queue",
                                     $time));
    endtask

    task automatic apb_transfer(input logic [31:0] addr, input logic wr,
                                input logic [31:0] data, input logic [31:0] exp);
        paddr   = addr[`ISSUE_APB_AW-1:0];
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge aclk);
        penable = 1'b1;
        if (!wr) begin
            assert (prdata == exp)
                else abort_run($sformatf("CHECK FAILED at %0t: offset %0h read %h, expected %h",
                                         $time, addr, prdata, exp));
        end
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_drain();
        finish_held();
        while (pending != '0) @(negedge aclk);
    endtask

    // writebacks may come in any order and are matched by destination
    always @(negedge aclk) begin
        if (rst_n && wb_valid) begin
            assert (pending[wb_prd])
                else abort_run($sformatf("unexpected writeback to p%0d at %0t, nothing pending",
                                         wb_prd, $time));
            assert (wb_data == exp_val[wb_prd])
                else abort_run($sformatf("CHECK FAILED at %0t: p%0d wrote %h, expected %h",
                                         $time, wb_prd, wb_data, exp_val[wb_prd]));
            pending[wb_prd] = 1'b0;
        end
    end

    initial begin
        wait (loaded);
        repeat (rec_count * WD_CYCLES) @(posedge aclk);
        $display("watchdog timeout after %0d cycles, the run did not finish",
                 rec_count * WD_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int b;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        dispatch_valid = 1'b0;
        dispatch_op    = ALU_ADD;
        dispatch_prd   = '0;
        dispatch_prs1  = '0;
        dispatch_prs2  = '0;
        dispatch_imm   = '0;
        pending        = '0;
        held           = 1'b0;
        loaded         = 1'b0;
        lfsr_q         = 17'd90213;
        $readmemh(PAT_FILE, pat_mem);
        rec_count = 0;
        while (rec_count < MAX_REC && pat_mem[rec_count*REC_W] != REC_END) begin
            rec_count++;
        end
        loaded = 1'b1;
        wait (rst_n);
        @(negedge aclk);
        for (int r = 0; r < rec_count; r++) begin
            b = r * REC_W;
            case (pat_mem[b])
                REC_OP:    send_op(b, 1'b1);
                REC_DROP:  send_op(b, 1'b0);
                REC_HELD:  present_held_op(b);
                REC_WRITE: apb_transfer(pat_mem[b+1], 1'b1, pat_mem[b+6], '0);
                REC_READ:  apb_transfer(pat_mem[b+1], 1'b0, '0, pat_mem[b+7]);
                REC_DRAIN: wait_drain();
                default: begin
                    abort_run($sformatf("pattern record %0d has unknown kind %0h",
                                        r, pat_mem[b]));
                end
            endcase
        end
        wait_drain();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    // reset covers the first ten rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge aclk);
        rst_n_o = 1'b1;
    end

endmodule

//--- source/alu_issue_queue.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module alu_issue_queue (
    input  logic                     aclk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     issue_en_i,
    input  logic                     dispatch_valid_i,
    output logic                     dispatch_ready_o,
    input  uop_pkg::alu_op_e         dispatch_op_i,
    input  uop_pkg::prf_num_t        dispatch_prd_i,
    input  uop_pkg::prf_num_t        dispatch_prs1_i,
    input  uop_pkg::prf_num_t        dispatch_prs2_i,
    input  uop_pkg::xlen_t           dispatch_imm_i,
    input  logic                     src1_ready_i,
    input  logic                     src2_ready_i,
    output logic                     set_busy_o,
    input  logic                     wb_valid_i,
    input  uop_pkg::prf_num_t        wb_prd_i,
    output logic                     issue_valid_o,
    output uop_pkg::alu_op_e         issue_op_o,
    output uop_pkg::prf_num_t        issue_prs1_o,
    output uop_pkg::prf_num_t        issue_prs2_o,
    output uop_pkg::prf_num_t        issue_prd_o,
    output uop_pkg::xlen_t           issue_imm_o,
    output logic [`ISSUE_IQ_CW-1:0]  count_o
);
    import uop_pkg::*;

    localparam int IQ_DEPTH = `ISSUE_IQ_DEPTH;
    localparam int IDX_W    = $clog2(IQ_DEPTH);
    localparam logic [`ISSUE_IQ_CW-1:0] FULL_COUNT = `ISSUE_IQ_CW'(IQ_DEPTH);

    // collapsing queue, entry 0 is the oldest
    alu_op_e  op_q   [IQ_DEPTH];
    prf_num_t prd_q  [IQ_DEPTH];
    prf_num_t prs1_q [IQ_DEPTH];
    prf_num_t prs2_q [IQ_DEPTH];
    xlen_t    imm_q  [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] rdy1_q;
    logic [IQ_DEPTH-1:0] rdy2_q;

    alu_op_e  op_n   [IQ_DEPTH];
    prf_num_t prd_n  [IQ_DEPTH];
    prf_num_t prs1_n [IQ_DEPTH];
    prf_num_t prs2_n [IQ_DEPTH];
    xlen_t    imm_n  [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] rdy1_n;
    logic [IQ_DEPTH-1:0] rdy2_n;

    logic [IQ_DEPTH-1:0]     rdy1_w;
    logic [IQ_DEPTH-1:0]     rdy2_w;
    logic [IQ_DEPTH-1:0]     entry_ready;
    logic [`ISSUE_IQ_CW-1:0] count_q;
    logic [`ISSUE_IQ_CW-1:0] count_n;
    logic [`ISSUE_IQ_CW-1:0] tail;
    logic                    not_full_q;
    logic                    accept;
    logic                    do_issue;
    logic                    sel_found;
    logic [IDX_W-1:0]        sel_idx;

    // not_full_q resets low, so ready stays low while in reset
    assign dispatch_ready_o = not_full_q && !flush_i;
    assign accept           = dispatch_valid_i && dispatch_ready_o;
    assign set_busy_o       = accept;

    // wakeup by writeback tag, then pick the lowest ready slot
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            rdy1_w[i] = rdy1_q[i] || (wb_valid_i && wb_prd_i == prs1_q[i]);
            rdy2_w[i] = rdy2_q[i] || (wb_valid_i && wb_prd_i == prs2_q[i]);
            entry_ready[i] = (i < count_q) &&
                             (op_q[i] == ALU_LI || (rdy1_w[i] && rdy2_w[i]));
        end
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign do_issue = issue_en_i && sel_found && !flush_i;
    assign tail     = do_issue ? count_q - 1'b1 : count_q;

    always_comb begin
        count_n = count_q;
        if (accept && !do_issue) begin
            count_n = count_q + 1'b1;
        end else if (!accept && do_issue) begin
            count_n = count_q - 1'b1;
        end
    end

    // next entry contents: close the gap left by the issued op, then append
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            op_n[i]   = op_q[i];
            prd_n[i]  = prd_q[i];
            prs1_n[i] = prs1_q[i];
            prs2_n[i] = prs2_q[i];
            imm_n[i]  = imm_q[i];
            rdy1_n[i] = rdy1_w[i];
            rdy2_n[i] = rdy2_w[i];
        end
        if (do_issue) begin
            for (int i = 0; i < IQ_DEPTH - 1; i++) begin
                if (i >= sel_idx) begin
                    op_n[i]   = op_q[i+1];
                    prd_n[i]  = prd_q[i+1];
                    prs1_n[i] = prs1_q[i+1];
                    prs2_n[i] = prs2_q[i+1];
                    imm_n[i]  = imm_q[i+1];
                    rdy1_n[i] = rdy1_w[i+1];
                    rdy2_n[i] = rdy2_w[i+1];
                end
            end
        end
        if (accept) begin
            op_n[tail[IDX_W-1:0]]   = dispatch_op_i;
            prd_n[tail[IDX_W-1:0]]  = dispatch_prd_i;
            prs1_n[tail[IDX_W-1:0]] = dispatch_prs1_i;
            prs2_n[tail[IDX_W-1:0]] = dispatch_prs2_i;
            imm_n[tail[IDX_W-1:0]]  = dispatch_imm_i;
            rdy1_n[tail[IDX_W-1:0]] = src1_ready_i;
            rdy2_n[tail[IDX_W-1:0]] = src2_ready_i;
        end
    end

    always_ff @(posedge aclk) begin
        op_q   <= op_n;
        prd_q  <= prd_n;
        prs1_q <= prs1_n;
        prs2_q <= prs2_n;
        imm_q  <= imm_n;
        rdy1_q <= rdy1_n;
        rdy2_q <= rdy2_n;
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            count_q    <= '0;
            not_full_q <= 1'b0;
        end else if (flush_i) begin
            count_q    <= '0;
            not_full_q <= 1'b1;
        end else begin
            count_q    <= count_n;
            not_full_q <= (count_n != FULL_COUNT);
        end
    end

    // issue register
    always_ff @(posedge aclk) begin
        if (!rst_n_i || flush_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= do_issue;
        end
    end

    always_ff @(posedge aclk) begin
        if (do_issue) begin
            issue_op_o   <= op_q[sel_idx];
            issue_prs1_o <= prs1_q[sel_idx];
            issue_prs2_o <= prs2_q[sel_idx];
            issue_prd_o  <= prd_q[sel_idx];
            issue_imm_o  <= imm_q[sel_idx];
        end
    end

    assign count_o = count_q;

endmodule

//--- source/busy_scoreboard.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module busy_scoreboard (
    input  logic              aclk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              set_en_i,
    input  uop_pkg::prf_num_t set_num_i,
    input  logic              wb_valid_i,
    input  uop_pkg::prf_num_t wb_prd_i,
    input  uop_pkg::prf_num_t rd_num1_i,
    input  uop_pkg::prf_num_t rd_num2_i,
    output logic              src1_ready_o,
    output logic              src2_ready_o
);

    // one bit per physical register, set while a result is pending
    logic [`ISSUE_PRF_DEPTH-1:0] busy_q;
    logic                        wb_hit1;
    logic                        wb_hit2;

    always_ff @(posedge aclk) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= '0;
        end else begin
            if (wb_valid_i) begin
                busy_q[wb_prd_i] <= 1'b0;
            end
            // a new producer of the same register wins over the old writeback
            if (set_en_i) begin
                busy_q[set_num_i] <= 1'b1;
            end
        end
    end

    // bypass the writeback of this cycle, the bit only clears on the edge
    assign wb_hit1 = wb_valid_i && (wb_prd_i == rd_num1_i);
    assign wb_hit2 = wb_valid_i && (wb_prd_i == rd_num2_i);

    assign src1_ready_o = !busy_q[rd_num1_i] || wb_hit1;
    assign src2_ready_o = !busy_q[rd_num2_i] || wb_hit2;

endmodule

//--- source/csr_pkg.sv
`include "issue_slice_params.svh"

package csr_pkg;

    // register offsets on the APB side
    typedef enum logic [`ISSUE_APB_AW-1:0] {
        CSR_CTRL   = 4'h0,
        CSR_STATUS = 4'h4
    } csr_addr_e;

    // CTRL bit positions
    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1;

endpackage

//--- source/issue_ctrl_regs.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module issue_ctrl_regs (
    input  logic                      aclk,
    input  logic                      rst_n_i,
    input  logic [`ISSUE_APB_AW-1:0]  paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    input  logic [`ISSUE_IQ_CW-1:0]   iq_count_i,
    output logic                      issue_en_o,
    output logic                      flush_o
);
    import csr_pkg::*;

    logic      wr_access;
    logic      issue_en_q;
    logic      flush_q;
    csr_addr_e reg_sel;

    // no wait states, so the access phase always completes
    assign wr_access = psel_i && penable_i && pwrite_i;
    assign reg_sel   = csr_addr_e'(paddr_i);

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            issue_en_q <= 1'b1;
            flush_q    <= 1'b0;
        end else begin
            // flush is self clearing, one cycle wide
            flush_q <= 1'b0;
            if (wr_access && reg_sel == CSR_CTRL) begin
                issue_en_q <= pwdata_i[CTRL_EN_BIT];
                flush_q    <= pwdata_i[CTRL_FLUSH_BIT];
            end
        end
    end

    // read mux, flush bit never reads back
    always_comb begin
        prdata_o = '0;
        case (reg_sel)
            CSR_CTRL: begin
                prdata_o[CTRL_EN_BIT] = issue_en_q;
            end
            CSR_STATUS: begin
                prdata_o[`ISSUE_IQ_CW-1:0] = iq_count_i;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

    assign issue_en_o = issue_en_q;
    assign flush_o    = flush_q;

endmodule

//--- source/issue_slice_params.svh
`ifndef ISSUE_SLICE_PARAMS_SVH
`define ISSUE_SLICE_PARAMS_SVH

// datapath width
`define ISSUE_XLEN 32

// physical register file
`define ISSUE_PRF_DEPTH 32
`define ISSUE_PRF_AW 5

// ALU issue queue, count is wide enough to hold the full depth
`define ISSUE_IQ_DEPTH 8
`define ISSUE_IQ_CW 4

// APB control block
`define ISSUE_APB_AW 4

`endif

//--- source/issue_slice_top.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module issue_slice_top (
    input  logic                     aclk,
    input  logic                     rst_n_i,
    input  logic [`ISSUE_APB_AW-1:0] paddr_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [31:0]              pwdata_i,
    output logic [31:0]              prdata_o,
    input  logic                     dispatch_valid_i,
    output logic                     dispatch_ready_o,
    input  uop_pkg::alu_op_e         dispatch_op_i,
    input  uop_pkg::prf_num_t        dispatch_prd_i,
    input  uop_pkg::prf_num_t        dispatch_prs1_i,
    input  uop_pkg::prf_num_t        dispatch_prs2_i,
    input  uop_pkg::xlen_t           dispatch_imm_i,
    output logic                     wb_valid_o,
    output uop_pkg::prf_num_t        wb_prd_o,
    output uop_pkg::xlen_t           wb_data_o
);
    import uop_pkg::*;

    logic                    issue_en;
    logic                    flush;
    logic [`ISSUE_IQ_CW-1:0] iq_count;
    logic                    set_busy;
    logic                    src1_ready;
    logic                    src2_ready;
    logic                    issue_valid;
    alu_op_e                 issue_op;
    prf_num_t                issue_prs1;
    prf_num_t                issue_prs2;
    prf_num_t                issue_prd;
    xlen_t                   issue_imm;

    issue_ctrl_regs u_ctrl_regs (
        .aclk       (aclk),
        .rst_n_i    (rst_n_i),
        .paddr_i    (paddr_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .iq_count_i (iq_count),
        .issue_en_o (issue_en),
        .flush_o    (flush)
    );

    // lookups come straight from the op on the dispatch port
    busy_scoreboard u_scoreboard (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .set_en_i     (set_busy),
        .set_num_i    (dispatch_prd_i),
        .wb_valid_i   (wb_valid_o),
        .wb_prd_i     (wb_prd_o),
        .rd_num1_i    (dispatch_prs1_i),
        .rd_num2_i    (dispatch_prs2_i),
        .src1_ready_o (src1_ready),
        .src2_ready_o (src2_ready)
    );

    alu_issue_queue u_issue_queue (
        .aclk             (aclk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush),
        .issue_en_i       (issue_en),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .dispatch_op_i    (dispatch_op_i),
        .dispatch_prd_i   (dispatch_prd_i),
        .dispatch_prs1_i  (dispatch_prs1_i),
        .dispatch_prs2_i  (dispatch_prs2_i),
        .dispatch_imm_i   (dispatch_imm_i),
        .src1_ready_i     (src1_ready),
        .src2_ready_i     (src2_ready),
        .set_busy_o       (set_busy),
        .wb_valid_i       (wb_valid_o),
        .wb_prd_i         (wb_prd_o),
        .issue_valid_o    (issue_valid),
        .issue_op_o       (issue_op),
        .issue_prs1_o     (issue_prs1),
        .issue_prs2_o     (issue_prs2),
        .issue_prd_o      (issue_prd),
        .issue_imm_o      (issue_imm),
        .count_o          (iq_count)
    );

    prf_alu_exec u_exec (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_prs1_i  (issue_prs1),
        .issue_prs2_i  (issue_prs2),
        .issue_prd_i   (issue_prd),
        .issue_imm_i   (issue_imm),
        .wb_valid_o    (wb_valid_o),
        .wb_prd_o      (wb_prd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

//--- source/prf_alu_exec.sv
`timescale 1ns/1ps
`include "issue_slice_params.svh"

module prf_alu_exec (
    input  logic              aclk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              issue_valid_i,
    input  uop_pkg::alu_op_e  issue_op_i,
    input  uop_pkg::prf_num_t issue_prs1_i,
    input  uop_pkg::prf_num_t issue_prs2_i,
    input  uop_pkg::prf_num_t issue_prd_i,
    input  uop_pkg::xlen_t    issue_imm_i,
    output logic              wb_valid_o,
    output uop_pkg::prf_num_t wb_prd_o,
    output uop_pkg::xlen_t    wb_data_o
);
    import uop_pkg::*;

    xlen_t prf_q [`ISSUE_PRF_DEPTH];
    xlen_t src1;
    xlen_t src2;
    xlen_t result;
    logic  wr_en;

    // operand read from the register file
    assign src1 = prf_q[issue_prs1_i];
    assign src2 = prf_q[issue_prs2_i];

    always_comb begin
        case (issue_op_i)
            ALU_ADD: result = src1 + src2;
            ALU_SUB: result = src1 - src2;
            ALU_AND: result = src1 & src2;
            ALU_OR:  result = src1 | src2;
            ALU_XOR: result = src1 ^ src2;
            ALU_SLT: begin
                result = '0;
                result[0] = $signed(src1) < $signed(src2);
            end
            // shift amount is the low five bits of source 2
            ALU_SLL: result = src1 << src2[4:0];
            ALU_LI:  result = issue_imm_i;
            default: result = '0;
        endcase
    end

    // an op caught by a flush leaves no trace in the register file
    assign wr_en = issue_valid_i && !flush_i;

    always_ff @(posedge aclk) begin
        if (!rst_n_i || flush_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            wb_prd_o  <= issue_prd_i;
            wb_data_o <= result;
            prf_q[issue_prd_i] <= result;
        end
    end

endmodule

//--- source/uop_pkg.sv
`include "issue_slice_params.svh"

package uop_pkg;

    // ALU opcodes, LI loads the immediate and ignores both sources
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_LI  = 3'd7
    } alu_op_e;

    // physical register number
    typedef logic [`ISSUE_PRF_AW-1:0] prf_num_t;

    // data word
    typedef logic [`ISSUE_XLEN-1:0] xlen_t;

endpackage
